//--- dv/tb_io_dma_bridge.sv
// Testbench for the I/O to DMA bridge
// Sends memory commands, models each DMA channel with a word array and
// random stalls, and checks responses and DMA packets against a shadow memory

`timescale 1ns/1ps

module tb_io_dma_bridge;

   localparam int NUM_DMA    = 2;
   localparam int NUM_RAND   = 200;
   localparam int MAX_CYCLES = NUM_RAND * 60 + 500;
   localparam int WORDS      = 64;

   typedef struct packed
   {
      bridge_mem_pkg::mem_hdr_s  hdr;
      bridge_mem_pkg::mem_line_t data;
   } resp_s;

   typedef enum logic [1:0] {M_IDLE, M_WR, M_RD} mdl_state_e;

   logic                                    clk_i, rst_i;
   bridge_mem_pkg::mem_hdr_s                mem_cmd_hdr_i, mem_resp_hdr_o;
   bridge_mem_pkg::mem_line_t               mem_cmd_data_i, mem_resp_data_o;
   logic                                    mem_cmd_v_i, mem_cmd_ready_o;
   logic                                    mem_resp_v_o, mem_resp_ready_i;
   bridge_mem_pkg::dma_pkt_s  [NUM_DMA-1:0] dma_pkt_o;
   logic                      [NUM_DMA-1:0] dma_pkt_v_o, dma_pkt_yumi_i;
   bridge_mem_pkg::dma_word_t [NUM_DMA-1:0] dma_data_o, dma_data_i;
   logic                      [NUM_DMA-1:0] dma_data_v_o, dma_data_yumi_i;
   logic                      [NUM_DMA-1:0] dma_data_v_i, dma_data_ready_o;

   logic [15:0]               lfsr_r = 16'd15;
   mdl_state_e                mdl_state [NUM_DMA];
   int                        mdl_beat [NUM_DMA];
   bridge_mem_pkg::mem_addr_t mdl_addr [NUM_DMA];
   logic                      rd_hold [NUM_DMA];
   bridge_mem_pkg::dma_word_t dma_mem [NUM_DMA][WORDS];
   bridge_mem_pkg::mem_line_t shadow_mem [bridge_mem_pkg::mem_addr_t];
   resp_s                     exp_resp_q [$];
   bridge_mem_pkg::dma_pkt_s  exp_pkt_q [$];
   bridge_mem_pkg::mem_hdr_s  rnd_hdr [NUM_RAND];
   bridge_mem_pkg::mem_line_t rnd_line [NUM_RAND];
   int                        cur_chan = 0;
   int                        sent = 0;
   int                        resp_count = 0;
   int                        cycles = 0;

   io_dma_bridge #(.NUM_DMA_P(NUM_DMA)) uut
     (.clk_i(clk_i), .rst_i(rst_i),
      .mem_cmd_hdr_i(mem_cmd_hdr_i), .mem_cmd_data_i(mem_cmd_data_i),
      .mem_cmd_v_i(mem_cmd_v_i), .mem_cmd_ready_o(mem_cmd_ready_o),
      .mem_resp_hdr_o(mem_resp_hdr_o), .mem_resp_data_o(mem_resp_data_o),
      .mem_resp_v_o(mem_resp_v_o), .mem_resp_ready_i(mem_resp_ready_i),
      .dma_pkt_o(dma_pkt_o), .dma_pkt_v_o(dma_pkt_v_o), .dma_pkt_yumi_i(dma_pkt_yumi_i),
      .dma_data_o(dma_data_o), .dma_data_v_o(dma_data_v_o),
      .dma_data_yumi_i(dma_data_yumi_i),
      .dma_data_i(dma_data_i), .dma_data_v_i(dma_data_v_i),
      .dma_data_ready_o(dma_data_ready_o));

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic rand_bit();
      lfsr_r = lfsr_step(lfsr_r);
      return lfsr_r[0];
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
         r = {r[62:0], rand_bit()};
      return r;
   endfunction

   // Channel from the address bits above the line offset
   function automatic int expected_chan(input bridge_mem_pkg::mem_addr_t addr);
      int cord;
      cord = int'(addr >> bridge_mem_pkg::LINE_OFFSET_W) & ((1 << $clog2(NUM_DMA)) - 1);
      return cord % NUM_DMA;
   endfunction

   function automatic int word_idx(input bridge_mem_pkg::mem_addr_t addr);
      return int'(addr[7:2]);
   endfunction

   function automatic bridge_mem_pkg::mem_line_t model_line(input int c,
                                                            input bridge_mem_pkg::mem_addr_t addr);
      return {dma_mem[c][word_idx(addr) + 1], dma_mem[c][word_idx(addr)]};
   endfunction

   // Reads see the last written line or zero, writes answer with zero data
   function automatic resp_s expected_resp(input bridge_mem_pkg::mem_hdr_s hdr);
      resp_s r;
      r.hdr  = hdr;
      r.data = '0;
      if (hdr.op == bridge_mem_pkg::MEM_RD && shadow_mem.exists(hdr.addr))
         r.data = shadow_mem[hdr.addr];
      return r;
   endfunction

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_hdr(input bridge_mem_pkg::mem_hdr_s got,
                            input bridge_mem_pkg::mem_hdr_s exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: response header op %0d addr %06h, expected op %0d addr %06h",
                  $time, got.op, got.addr, exp.op, exp.addr);
         abort_run();
      end
   endtask

   task automatic check_line(input bridge_mem_pkg::mem_line_t got,
                             input bridge_mem_pkg::mem_line_t exp, input string what);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s is %016h, expected %016h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_pkt(input bridge_mem_pkg::dma_pkt_s got,
                            input bridge_mem_pkg::dma_pkt_s exp, input int c);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: DMA packet on channel %0d wr %0b addr %06h, %s %0b addr %06h",
                  $time, c, got.wr, got.addr, "expected wr", exp.wr, exp.addr);
         abort_run();
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s is %0b, expected %0b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic send_cmd(input bridge_mem_pkg::mem_hdr_s hdr,
                           input bridge_mem_pkg::mem_line_t line);
      bridge_mem_pkg::dma_pkt_s  pkt;
      bridge_mem_pkg::mem_addr_t ofs;
      ofs      = bridge_mem_pkg::mem_addr_t'((1 << bridge_mem_pkg::LINE_OFFSET_W) - 1);
      pkt.wr   = (hdr.op == bridge_mem_pkg::MEM_WR);
      pkt.addr = hdr.addr & ~ofs;
      @(negedge clk_i);
      mem_cmd_hdr_i  = hdr;
      mem_cmd_data_i = line;
      mem_cmd_v_i    = 1'b1;
      while (!mem_cmd_ready_o)
         @(negedge clk_i);
      cur_chan = expected_chan(hdr.addr);   // Taken at the coming edge
      exp_resp_q.push_back(expected_resp(hdr));
      exp_pkt_q.push_back(pkt);
      if (pkt.wr)
         shadow_mem[hdr.addr] = line;
      sent++;
      @(negedge clk_i);
      mem_cmd_v_i = 1'b0;
   endtask

   // Stall bits and read beats toward the DUT
   initial
   begin
      mem_resp_ready_i = 1'b0;
      dma_pkt_yumi_i   = '0;
      dma_data_yumi_i  = '0;
      dma_data_v_i     = '0;
      dma_data_i       = '0;
      forever
      begin
         @(negedge clk_i);
         mem_resp_ready_i = rand_bit();
         for (int c = 0; c < NUM_DMA; c++)
         begin
            dma_pkt_yumi_i[c]  = dma_pkt_v_o[c] & rand_bit();   // Yumi only with valid
            dma_data_yumi_i[c] = dma_data_v_o[c] & rand_bit();
            dma_data_v_i[c]    = (mdl_state[c] == M_RD) & (rd_hold[c] | rand_bit());
            dma_data_i[c]      = dma_mem[c][word_idx(mdl_addr[c]) + mdl_beat[c]];
         end
      end
   end

   // DMA channel models
   initial
   begin
      for (int c = 0; c < NUM_DMA; c++)
      begin
         mdl_state[c] = M_IDLE;
         mdl_beat[c]  = 0;
         mdl_addr[c]  = '0;
         rd_hold[c]   = 1'b0;
         for (int w = 0; w < WORDS; w++)
            dma_mem[c][w] = '0;
      end
      forever
      begin
         @(posedge clk_i);
         for (int c = 0; c < NUM_DMA; c++)
         begin
            rd_hold[c] = dma_data_v_i[c] & ~dma_data_ready_o[c];
            case (mdl_state[c])
               M_IDLE:
                  if (dma_pkt_v_o[c] && dma_pkt_yumi_i[c])
                  begin
                     mdl_addr[c]  = dma_pkt_o[c].addr;
                     mdl_beat[c]  = 0;
                     mdl_state[c] = dma_pkt_o[c].wr ? M_WR : M_RD;
                  end
               M_WR:
                  if (dma_data_v_o[c] && dma_data_yumi_i[c])
                  begin
                     dma_mem[c][word_idx(mdl_addr[c]) + mdl_beat[c]] = dma_data_o[c];
                     mdl_beat[c]++;
                  end
               default:
                  if (dma_data_v_i[c] && dma_data_ready_o[c])
                     mdl_beat[c]++;
            endcase
            if (mdl_beat[c] == bridge_mem_pkg::DMA_BEATS)
            begin
               mdl_beat[c]  = 0;
               mdl_state[c] = M_IDLE;
            end
         end
      end
   end

   always @(posedge clk_i)
   begin
      bridge_mem_pkg::dma_pkt_s exp;
      if (!rst_i)
         for (int c = 0; c < NUM_DMA; c++)
         begin
            if (c != cur_chan)
               check_flag(dma_pkt_v_o[c] | dma_data_v_o[c] | dma_data_ready_o[c], 1'b0,
                          "DMA activity on an unselected channel");
            if (dma_pkt_v_o[c] && dma_pkt_yumi_i[c])
            begin
               if (exp_pkt_q.size() == 0)
               begin
                  $display("A DMA packet was issued with no command outstanding");
                  abort_run();
               end
               else
               begin
                  exp = exp_pkt_q.pop_front();
                  check_pkt(dma_pkt_o[c], exp, c);
               end
            end
         end
   end

   // Response compare
   always @(posedge clk_i)
   begin
      resp_s exp;
      if (!rst_i && mem_resp_v_o && mem_resp_ready_i)
      begin
         if (exp_resp_q.size() == 0)
         begin
            $display("A memory response arrived with no command outstanding");
            abort_run();
         end
         else
         begin
            exp = exp_resp_q.pop_front();
            check_hdr(mem_resp_hdr_o, exp.hdr);
            check_line(mem_resp_data_o, exp.data, "response data");
            if (exp.hdr.op == bridge_mem_pkg::MEM_WR)
               check_line(model_line(expected_chan(exp.hdr.addr), exp.hdr.addr),
                          shadow_mem[exp.hdr.addr], "DMA model line");
            resp_count++;
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycles++;
      if (cycles > MAX_CYCLES)
      begin
         $display("The simulation timed out after %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   initial
   begin
      bridge_mem_pkg::mem_hdr_s hdr;
      rst_i          = 1'b1;
      mem_cmd_v_i    = 1'b0;
      mem_cmd_hdr_i  = '0;
      mem_cmd_data_i = '0;
      for (int i = 0; i < NUM_RAND; i++)
      begin
         rnd_hdr[i].op   = rand_bit() ? bridge_mem_pkg::MEM_WR : bridge_mem_pkg::MEM_RD;
         rnd_hdr[i].addr =
            bridge_mem_pkg::mem_addr_t'(rand_bits(5) << bridge_mem_pkg::LINE_OFFSET_W);
         rnd_line[i]     = rand_bits(64);
      end
      repeat (2) @(negedge clk_i);
      rst_i = 1'b0;

      repeat (4)   // Quiet outputs before the first command
      begin
         @(negedge clk_i);
         check_flag(mem_resp_v_o, 1'b0, "mem_resp_v_o after reset");
         check_flag(|dma_pkt_v_o, 1'b0, "dma_pkt_v_o after reset");
         check_flag(|dma_data_v_o, 1'b0, "dma_data_v_o after reset");
      end

      hdr.op   = bridge_mem_pkg::MEM_WR;
      hdr.addr = 24'h000048;               // Channel 1
      send_cmd(hdr, 64'h0123_4567_89ab_cdef);
      hdr.op = bridge_mem_pkg::MEM_RD;
      send_cmd(hdr, '0);
      hdr.op   = bridge_mem_pkg::MEM_WR;
      hdr.addr = 24'h000030;               // Channel 0
      send_cmd(hdr, 64'hfeed_0001_cafe_0002);
      hdr.op = bridge_mem_pkg::MEM_RD;
      send_cmd(hdr, '0);

      for (int i = 0; i < NUM_RAND; i++)
         send_cmd(rnd_hdr[i], rnd_line[i]);
      while (resp_count < sent)
         @(negedge clk_i);

      if (exp_pkt_q.size() != 0 || exp_resp_q.size() != 0)
      begin
         $display("Expected DMA packets or responses never arrived");
         abort_run();
      end
      else
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

//--- logic/bridge_mem_pkg.sv
// Memory message and DMA types
// Command and response headers, line data, DMA packet and beat formats
// shared by the message side and the DMA side of the bridge

package bridge_mem_pkg;

   typedef enum logic [1:0]
   {
      MEM_RD = 2'b00,
      MEM_WR = 2'b01
   } mem_op_e;

   typedef logic [23:0] mem_addr_t;   // Byte address, lines 8-byte aligned
   typedef logic [63:0] mem_line_t;
   typedef logic [31:0] dma_word_t;

   localparam int DMA_BEATS     = 2;  // Low beat first
   localparam int LINE_OFFSET_W = 3;

   typedef struct packed
   {
      mem_op_e   op;
      mem_addr_t addr;
   } mem_hdr_s;

   typedef struct packed
   {
      logic      wr;
      mem_addr_t addr;                // Line address
   } dma_pkt_s;

endpackage

//--- logic/bridge_noc_pkg.sv
// Wormhole link types
// One 32-bit flit word, read either as a header flit or as raw data,
// plus the forward half of a ready/valid link

package bridge_noc_pkg;

   localparam int FLIT_W = 32;

   typedef struct packed
   {
      logic [1:0]  cord;              // Destination channel
      logic [3:0]  len;               // Flits after the header
      logic [1:0]  op;
      logic [23:0] addr;
   } wh_hdr_flit_s;

   typedef union packed
   {
      wh_hdr_flit_s      hdr;
      logic [FLIT_W-1:0] data;
   } wh_flit_u;

   // Ready travels back as its own signal
   typedef struct packed
   {
      wh_flit_u flit;
      logic     v;
   } wh_link_s;

endpackage

//--- logic/dma_channel_mux.sv
// DMA channel steering
// Routes the packet and write beats to the selected channel and
// returns that channel's yumi and read beats

`timescale 1ns/1ps

module dma_channel_mux
  #(parameter  int NUM_DMA_P = 2,
    localparam int SEL_W     = (NUM_DMA_P > 1) ? $clog2(NUM_DMA_P) : 1)
   (input  logic [SEL_W-1:0]                          sel_i,
    input  bridge_mem_pkg::dma_pkt_s                  pkt_i,
    input  logic                                      pkt_v_i,
    output logic                                      pkt_yumi_o,
    input  bridge_mem_pkg::dma_word_t                 wr_beat_i,
    input  logic                                      wr_v_i,
    output logic                                      wr_yumi_o,
    output bridge_mem_pkg::dma_word_t                 rd_beat_o,
    output logic                                      rd_v_o,
    input  logic                                      rd_ready_i,
    output bridge_mem_pkg::dma_pkt_s  [NUM_DMA_P-1:0] dma_pkt_o,
    output logic                      [NUM_DMA_P-1:0] dma_pkt_v_o,
    input  logic                      [NUM_DMA_P-1:0] dma_pkt_yumi_i,
    output bridge_mem_pkg::dma_word_t [NUM_DMA_P-1:0] dma_data_o,
    output logic                      [NUM_DMA_P-1:0] dma_data_v_o,
    input  logic                      [NUM_DMA_P-1:0] dma_data_yumi_i,
    input  bridge_mem_pkg::dma_word_t [NUM_DMA_P-1:0] dma_data_i,
    input  logic                      [NUM_DMA_P-1:0] dma_data_v_i,
    output logic                      [NUM_DMA_P-1:0] dma_data_ready_o);

   always_comb
   begin
      for (int c = 0; c < NUM_DMA_P; c++)
      begin
         dma_pkt_o[c]        = pkt_i;      // Payload broadcast, valids steered
         dma_data_o[c]       = wr_beat_i;
         dma_pkt_v_o[c]      = pkt_v_i && (sel_i == SEL_W'(c));
         dma_data_v_o[c]     = wr_v_i && (sel_i == SEL_W'(c));
         dma_data_ready_o[c] = rd_ready_i && (sel_i == SEL_W'(c));
      end
      pkt_yumi_o = dma_pkt_yumi_i[sel_i];
      wr_yumi_o  = dma_data_yumi_i[sel_i];
      rd_beat_o  = dma_data_i[sel_i];
      rd_v_o     = dma_data_v_i[sel_i];
   end

endmodule

//--- logic/dma_fanout_ctrl.sv
// DMA fanout controller
// Decodes command flits, picks the channel from the header cord,
// runs one DMA packet with its beats and hands the reply to the packer

`timescale 1ns/1ps

module dma_fanout_ctrl
  #(parameter  int NUM_DMA_P = 2,
    localparam int SEL_W     = (NUM_DMA_P > 1) ? $clog2(NUM_DMA_P) : 1)
   (input  logic                      clk_i,
    input  logic                      rst_i,
    input  bridge_noc_pkg::wh_link_s  cmd_link_i,
    output logic                      cmd_link_ready_o,
    output logic [SEL_W-1:0]          sel_o,
    output bridge_mem_pkg::dma_pkt_s  pkt_o,
    output logic                      pkt_v_o,
    input  logic                      pkt_yumi_i,
    output bridge_mem_pkg::dma_word_t wr_beat_o,
    output logic                      wr_v_o,
    input  logic                      wr_yumi_i,
    input  bridge_mem_pkg::dma_word_t rd_beat_i,
    input  logic                      rd_v_i,
    output logic                      rd_ready_o,
    output bridge_mem_pkg::mem_hdr_s  resp_hdr_o,
    output bridge_mem_pkg::mem_line_t resp_data_o,
    output logic                      resp_start_o,
    input  logic                      packer_busy_i);

   typedef enum logic [2:0] {S_HDR, S_DATA, S_PKT, S_WR, S_RD, S_REPLY} state_e;

   localparam int                WW        = $bits(bridge_mem_pkg::dma_word_t);
   localparam int                BEAT_W    = $clog2(bridge_mem_pkg::DMA_BEATS);
   localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(bridge_mem_pkg::DMA_BEATS - 1);
   localparam bridge_mem_pkg::mem_addr_t OFS_MASK =
      bridge_mem_pkg::mem_addr_t'((1 << bridge_mem_pkg::LINE_OFFSET_W) - 1);

   state_e                    state_r, state_n;
   logic [BEAT_W-1:0]         beat_r;
   logic [SEL_W-1:0]          sel_r;
   bridge_mem_pkg::mem_hdr_s  hdr_r;
   bridge_mem_pkg::mem_line_t line_r;
   bridge_noc_pkg::wh_flit_u  flit;
   logic                      flit_take, beat_take, is_wr, last_beat, start;

   assign flit      = cmd_link_i.flit;
   assign flit_take = cmd_link_i.v & cmd_link_ready_o;
   assign is_wr     = (hdr_r.op == bridge_mem_pkg::MEM_WR);
   assign last_beat = (beat_r == LAST_BEAT);
   assign start     = (state_r == S_REPLY) & ~packer_busy_i;
   assign beat_take = (state_r == S_DATA && flit_take) || (state_r == S_WR && wr_yumi_i)
                      || (state_r == S_RD && rd_v_i);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         S_HDR:   if (flit_take) state_n = (flit.hdr.len == '0) ? S_PKT : S_DATA;
         S_DATA:  if (flit_take && last_beat) state_n = S_PKT;
         S_PKT:   if (pkt_yumi_i) state_n = is_wr ? S_WR : S_RD;
         S_WR:    if (wr_yumi_i && last_beat) state_n = S_REPLY;
         S_RD:    if (rd_v_i && last_beat) state_n = S_REPLY;
         S_REPLY: if (start) state_n = S_HDR;
         default: state_n = S_HDR;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r <= S_HDR;
         beat_r  <= '0;
         sel_r   <= '0;
      end
      else
      begin
         state_r <= state_n;
         if (state_n != state_r)
            beat_r <= '0;
         else if (beat_take)
            beat_r <= beat_r + 1'b1;
         if (state_r == S_HDR && flit_take)
            sel_r <= SEL_W'(int'(flit.hdr.cord) % NUM_DMA_P);   // Wraps for 3 channels
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_r == S_HDR && flit_take)
      begin
         hdr_r.op   <= bridge_mem_pkg::mem_op_e'(flit.hdr.op);
         hdr_r.addr <= flit.hdr.addr;
      end
      if (beat_take && state_r != S_WR)
         line_r[beat_r*WW +: WW] <= (state_r == S_DATA) ? flit.data : rd_beat_i;
   end

   assign cmd_link_ready_o = (state_r == S_HDR) || (state_r == S_DATA);
   assign sel_o            = sel_r;
   assign pkt_v_o          = (state_r == S_PKT);
   assign pkt_o.wr         = is_wr;
   assign pkt_o.addr       = hdr_r.addr & ~OFS_MASK;
   assign wr_v_o           = (state_r == S_WR);
   assign wr_beat_o        = line_r[beat_r*WW +: WW];
   assign rd_ready_o       = (state_r == S_RD);
   assign resp_hdr_o       = hdr_r;
   assign resp_data_o      = is_wr ? '0 : line_r;
   assign resp_start_o     = start;

   // Sender and controller must agree on the packet format
   a_len_op: assert property (@(posedge clk_i) disable iff (rst_i)
      state_r == S_HDR && cmd_link_i.v |->
         flit.hdr.len == ((flit.hdr.op == bridge_mem_pkg::MEM_WR)
                          ? 4'(bridge_mem_pkg::DMA_BEATS) : 4'd0));

   a_pkt_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      pkt_v_o && !pkt_yumi_i |=> pkt_v_o);

endmodule

//--- logic/io_dma_bridge.sv
// I/O to DRAM bridge top level
// Memory command and response ports on one side, per-channel DMA
// ports on the other, joined through a command and a response flit link

`timescale 1ns/1ps

module io_dma_bridge
  #(parameter  int NUM_DMA_P = 2,
    localparam int SEL_W     = (NUM_DMA_P > 1) ? $clog2(NUM_DMA_P) : 1)
   (input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  bridge_mem_pkg::mem_hdr_s                  mem_cmd_hdr_i,
    input  bridge_mem_pkg::mem_line_t                 mem_cmd_data_i,
    input  logic                                      mem_cmd_v_i,
    output logic                                      mem_cmd_ready_o,
    output bridge_mem_pkg::mem_hdr_s                  mem_resp_hdr_o,
    output bridge_mem_pkg::mem_line_t                 mem_resp_data_o,
    output logic                                      mem_resp_v_o,
    input  logic                                      mem_resp_ready_i,
    output bridge_mem_pkg::dma_pkt_s  [NUM_DMA_P-1:0] dma_pkt_o,
    output logic                      [NUM_DMA_P-1:0] dma_pkt_v_o,
    input  logic                      [NUM_DMA_P-1:0] dma_pkt_yumi_i,
    output bridge_mem_pkg::dma_word_t [NUM_DMA_P-1:0] dma_data_o,
    output logic                      [NUM_DMA_P-1:0] dma_data_v_o,
    input  logic                      [NUM_DMA_P-1:0] dma_data_yumi_i,
    input  bridge_mem_pkg::dma_word_t [NUM_DMA_P-1:0] dma_data_i,
    input  logic                      [NUM_DMA_P-1:0] dma_data_v_i,
    output logic                      [NUM_DMA_P-1:0] dma_data_ready_o);

   bridge_noc_pkg::wh_link_s  cmd_link, resp_link;
   logic                      cmd_link_ready, resp_link_ready;
   logic [SEL_W-1:0]          sel;
   bridge_mem_pkg::dma_pkt_s  pkt;
   logic                      pkt_v, pkt_yumi;
   bridge_mem_pkg::dma_word_t wr_beat, rd_beat;
   logic                      wr_v, wr_yumi, rd_v, rd_ready;
   bridge_mem_pkg::mem_hdr_s  resp_hdr;
   bridge_mem_pkg::mem_line_t resp_data;
   logic                      resp_start, packer_busy;

   mem_link_send #(.NUM_DMA_P(NUM_DMA_P)) link_send
     (.clk_i(clk_i), .rst_i(rst_i),
      .mem_cmd_hdr_i(mem_cmd_hdr_i), .mem_cmd_data_i(mem_cmd_data_i),
      .mem_cmd_v_i(mem_cmd_v_i), .mem_cmd_ready_o(mem_cmd_ready_o),
      .mem_resp_hdr_o(mem_resp_hdr_o), .mem_resp_data_o(mem_resp_data_o),
      .mem_resp_v_o(mem_resp_v_o), .mem_resp_ready_i(mem_resp_ready_i),
      .cmd_link_o(cmd_link), .cmd_link_ready_i(cmd_link_ready),
      .resp_link_i(resp_link), .resp_link_ready_o(resp_link_ready));

   dma_fanout_ctrl #(.NUM_DMA_P(NUM_DMA_P)) fanout_ctrl
     (.clk_i(clk_i), .rst_i(rst_i),
      .cmd_link_i(cmd_link), .cmd_link_ready_o(cmd_link_ready),
      .sel_o(sel), .pkt_o(pkt), .pkt_v_o(pkt_v), .pkt_yumi_i(pkt_yumi),
      .wr_beat_o(wr_beat), .wr_v_o(wr_v), .wr_yumi_i(wr_yumi),
      .rd_beat_i(rd_beat), .rd_v_i(rd_v), .rd_ready_o(rd_ready),
      .resp_hdr_o(resp_hdr), .resp_data_o(resp_data),
      .resp_start_o(resp_start), .packer_busy_i(packer_busy));

   resp_flit_packer resp_packer
     (.clk_i(clk_i), .rst_i(rst_i),
      .resp_hdr_i(resp_hdr), .resp_data_i(resp_data),
      .resp_start_i(resp_start), .busy_o(packer_busy),
      .resp_link_o(resp_link), .resp_link_ready_i(resp_link_ready));

   dma_channel_mux #(.NUM_DMA_P(NUM_DMA_P)) channel_mux
     (.sel_i(sel),
      .pkt_i(pkt), .pkt_v_i(pkt_v), .pkt_yumi_o(pkt_yumi),
      .wr_beat_i(wr_beat), .wr_v_i(wr_v), .wr_yumi_o(wr_yumi),
      .rd_beat_o(rd_beat), .rd_v_o(rd_v), .rd_ready_i(rd_ready),
      .dma_pkt_o(dma_pkt_o), .dma_pkt_v_o(dma_pkt_v_o), .dma_pkt_yumi_i(dma_pkt_yumi_i),
      .dma_data_o(dma_data_o), .dma_data_v_o(dma_data_v_o),
      .dma_data_yumi_i(dma_data_yumi_i),
      .dma_data_i(dma_data_i), .dma_data_v_i(dma_data_v_i),
      .dma_data_ready_o(dma_data_ready_o));

endmodule

//--- logic/mem_link_send.sv
// Memory message to flit link sender
// Registers one command, sends it as a header flit plus data flits,
// then gathers the reply flits into a memory response

`timescale 1ns/1ps

module mem_link_send
  #(parameter int NUM_DMA_P = 2)
   (input  logic                      clk_i,
    input  logic                      rst_i,
    input  bridge_mem_pkg::mem_hdr_s  mem_cmd_hdr_i,
    input  bridge_mem_pkg::mem_line_t mem_cmd_data_i,
    input  logic                      mem_cmd_v_i,
    output logic                      mem_cmd_ready_o,
    output bridge_mem_pkg::mem_hdr_s  mem_resp_hdr_o,
    output bridge_mem_pkg::mem_line_t mem_resp_data_o,
    output logic                      mem_resp_v_o,
    input  logic                      mem_resp_ready_i,
    output bridge_noc_pkg::wh_link_s  cmd_link_o,
    input  logic                      cmd_link_ready_i,
    input  bridge_noc_pkg::wh_link_s  resp_link_i,
    output logic                      resp_link_ready_o);

   typedef enum logic [1:0] {S_IDLE, S_SEND, S_WAIT, S_RESP} state_e;

   localparam logic [1:0] CORD_MASK = 2'((1 << $clog2(NUM_DMA_P)) - 1);
   localparam int         FW        = bridge_noc_pkg::FLIT_W;

   state_e                    state_r, state_n;
   logic                      ready_r;
   logic [1:0]                cnt_r;          // Flit index, shared by send and receive
   logic [3:0]                rx_len_r;
   bridge_mem_pkg::mem_hdr_s  cmd_hdr_r, resp_hdr_r;
   bridge_mem_pkg::mem_line_t cmd_data_r, resp_data_r;
   bridge_noc_pkg::wh_flit_u  hdr_flit, data_flit;
   logic                      cmd_take, is_wr, send_last, rx_take, rx_last;

   assign cmd_take  = mem_cmd_v_i & ready_r;
   assign is_wr     = (cmd_hdr_r.op == bridge_mem_pkg::MEM_WR);
   assign send_last = (cnt_r == (is_wr ? 2'(bridge_mem_pkg::DMA_BEATS) : 2'd0));
   assign rx_take   = resp_link_i.v & resp_link_ready_o;
   assign rx_last   = (cnt_r == '0) ? (resp_link_i.flit.hdr.len == '0)
                                    : ({2'b00, cnt_r} == rx_len_r);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         S_IDLE:  if (cmd_take) state_n = S_SEND;
         S_SEND:  if (cmd_link_ready_i && send_last) state_n = S_WAIT;
         S_WAIT:  if (rx_take && rx_last) state_n = S_RESP;
         S_RESP:  if (mem_resp_ready_i) state_n = S_IDLE;
         default: state_n = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r <= S_IDLE;
         ready_r <= 1'b0;
         cnt_r   <= '0;
      end
      else
      begin
         state_r <= state_n;
         ready_r <= (state_n == S_IDLE);   // Low until the response is taken
         if (state_n != state_r)
            cnt_r <= '0;
         else if ((state_r == S_SEND && cmd_link_ready_i) || rx_take)
            cnt_r <= cnt_r + 2'd1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_take)
      begin
         cmd_hdr_r  <= mem_cmd_hdr_i;
         cmd_data_r <= mem_cmd_data_i;
      end
      if (rx_take)
      begin
         if (cnt_r == '0)
         begin
            resp_hdr_r.op   <= bridge_mem_pkg::mem_op_e'(resp_link_i.flit.hdr.op);
            resp_hdr_r.addr <= resp_link_i.flit.hdr.addr;
            rx_len_r        <= resp_link_i.flit.hdr.len;
            resp_data_r     <= '0;          // Writes report zero data
         end
         else
            resp_data_r[cnt_r[1]*FW +: FW] <= resp_link_i.flit.data;
      end
   end

   always_comb
   begin
      hdr_flit           = '0;
      hdr_flit.hdr.cord  = cmd_hdr_r.addr[bridge_mem_pkg::LINE_OFFSET_W +: 2] & CORD_MASK;
      hdr_flit.hdr.len   = is_wr ? 4'(bridge_mem_pkg::DMA_BEATS) : 4'd0;
      hdr_flit.hdr.op    = cmd_hdr_r.op;
      hdr_flit.hdr.addr  = cmd_hdr_r.addr;
      data_flit.data     = cmd_data_r[cnt_r[1]*FW +: FW];   // Low word at index 1
   end

   assign cmd_link_o.v      = (state_r == S_SEND);
   assign cmd_link_o.flit   = (cnt_r == '0) ? hdr_flit : data_flit;
   assign resp_link_ready_o = (state_r == S_WAIT);
   assign mem_cmd_ready_o   = ready_r;
   assign mem_resp_hdr_o    = resp_hdr_r;
   assign mem_resp_data_o   = resp_data_r;
   assign mem_resp_v_o      = (state_r == S_RESP);

   a_cmd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      cmd_link_o.v && !cmd_link_ready_i |=> cmd_link_o.v && $stable(cmd_link_o.flit));

endmodule

//--- logic/resp_flit_packer.sv
// Response flit packer
// Latches a reply on the start strobe and sends it as a header flit,
// followed by the data flits of a read

`timescale 1ns/1ps

module resp_flit_packer
   (input  logic                      clk_i,
    input  logic                      rst_i,
    input  bridge_mem_pkg::mem_hdr_s  resp_hdr_i,
    input  bridge_mem_pkg::mem_line_t resp_data_i,
    input  logic                      resp_start_i,
    output logic                      busy_o,
    output bridge_noc_pkg::wh_link_s  resp_link_o,
    input  logic                      resp_link_ready_i);

   localparam int FW = bridge_noc_pkg::FLIT_W;

   logic                      busy_r;
   logic [1:0]                cnt_r;
   bridge_mem_pkg::mem_hdr_s  hdr_r;
   bridge_mem_pkg::mem_line_t data_r;
   bridge_noc_pkg::wh_flit_u  hdr_flit, data_flit;
   logic                      is_rd, load, last;

   assign is_rd = (hdr_r.op == bridge_mem_pkg::MEM_RD);
   assign load  = resp_start_i & ~busy_r;
   assign last  = (cnt_r == (is_rd ? 2'(bridge_mem_pkg::DMA_BEATS) : 2'd0));

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         busy_r <= 1'b0;
         cnt_r  <= '0;
      end
      else if (load)
      begin
         busy_r <= 1'b1;
         cnt_r  <= '0;
      end
      else if (busy_r && resp_link_ready_i)
      begin
         cnt_r <= cnt_r + 2'd1;
         if (last)
            busy_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (load)
      begin
         hdr_r  <= resp_hdr_i;
         data_r <= resp_data_i;
      end
   end

   always_comb
   begin
      hdr_flit          = '0;           // Single return path, cord stays 0
      hdr_flit.hdr.len  = is_rd ? 4'(bridge_mem_pkg::DMA_BEATS) : 4'd0;
      hdr_flit.hdr.op   = hdr_r.op;
      hdr_flit.hdr.addr = hdr_r.addr;
      data_flit.data    = data_r[cnt_r[1]*FW +: FW];
   end

   assign resp_link_o.v    = busy_r;
   assign resp_link_o.flit = (cnt_r == '0) ? hdr_flit : data_flit;
   assign busy_o           = busy_r;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_io_dma_bridge -f sim.f

out=$(./obj_dir/Vtb_io_dma_bridge 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
   exit 0
else
   exit 1
fi

//--- sim.f
logic/bridge_mem_pkg.sv
logic/bridge_noc_pkg.sv
logic/mem_link_send.sv
logic/dma_fanout_ctrl.sv
logic/resp_flit_packer.sv
logic/dma_channel_mux.sv
logic/io_dma_bridge.sv
dv/tb_io_dma_bridge.sv
